/* cmp_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One comparison between code search and comparator
interface cmp_if import lock_types_pkg::*; ();

    logic  valid;     // Single-cycle request strobe
    code_t cand;      // Code typed by the user
    code_t ref_code;  // Stored code under test
    logic  done;      // One cycle after valid
    logic  ok;

    modport source (
        output valid, cand, ref_code,
        input  done, ok
    );

    modport target (
        input  valid, cand, ref_code,
        output done, ok
    );

endinterface

`default_nettype wire

/* code_cmp.sv */
`timescale 1ns/100ps
`default_nettype none

module code_cmp import lock_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    cmp_if.target chk
);

    logic [CODE_DIGITS-1:0] digit_eq;

    // Padding digits take part too, so a longer code never matches a shorter one
    always_comb begin
        for (int i = 0; i < CODE_DIGITS; i++) begin
            digit_eq[i] = (chk.cand[i] == chk.ref_code[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chk.done <= 1'b0;
        end else begin
            chk.done <= chk.valid;  // Fixed one-cycle answer
        end
    end

    always_ff @(posedge clk) begin
        if (chk.valid) begin
            chk.ok <= &digit_eq;
        end
    end

endmodule

`default_nettype wire

/* code_search.sv */
`timescale 1ns/100ps
`default_nettype none

module code_search import lock_types_pkg::*, lock_cfg_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    search_if.target req,
    cmp_if.source    chk
);

    logic                  busy;
    logic [CODE_IDX_W-1:0] idx;   // Stored code now being compared
    logic                  last;
    code_t                 cand_q;

    assign last = (idx == CODE_IDX_W'(NUM_CODES - 1));

    assign chk.cand     = cand_q;
    assign chk.ref_code = USER_CODES[idx];

    // Stop at the first hit or after the last stored code
    assign req.done  = chk.done && (chk.ok || last);
    assign req.match = chk.ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            chk.valid <= 1'b0;
        end else begin
            chk.valid <= 1'b0;
            if (req.start && !busy) begin
                busy      <= 1'b1;
                idx       <= '0;
                chk.valid <= 1'b1;
            end else if (chk.done) begin
                if (req.done) begin
                    busy <= 1'b0;
                end else begin
                    idx       <= idx + 1'b1;  // Try the next stored code
                    chk.valid <= 1'b1;
                end
            end
        end
    end

    // Candidate is held for the whole search
    always_ff @(posedge clk) begin
        if (req.start && !busy) begin
            cand_q <= req.code;
        end
    end

endmodule

`default_nettype wire

/* door_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module door_fsm import lock_types_pkg::*, lock_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      door_open,
    input  logic      inside_btn,
    input  code_t     code,
    input  logic      code_valid,
    search_if.source  req,
    output logic      lock,
    output logic      beep,
    output logic      keypad_en,
    output logic      blocked,
    output attempts_t attempts
);

    typedef enum logic [3:0] {
        INIT,
        LOCKED,            // Closed and latched
        AJAR,              // Closed, latch released
        OPEN,
        CHECKING,          // Waiting for the code search
        PENALTY,           // Keypad blocked after a wrong code
        UNLOCK_DEBOUNCE,
        LOCK_DEBOUNCE,
        TIMEOUT_BEEP,
        OPEN_ALARM
    } state_t;

    state_t             state;
    logic [TIMER_W-1:0] timer;  // Shared by debounce, auto-lock, alarm and lockout
    logic [TIMER_W-1:0] block_limit;
    code_t              code_q;

    assign block_limit = (attempts >= attempts_t'(MAX_ATTEMPTS)) ?
                         TIMER_W'(LONG_BLOCK_CYCLES - 1) : TIMER_W'(SHORT_BLOCK_CYCLES - 1);

    assign req.code = code_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= INIT;
            timer     <= '0;
            attempts  <= '0;
            req.start <= 1'b0;
        end else begin
            req.start <= 1'b0;
            case (state)
                INIT: begin
                    if (!door_open) state <= LOCKED;
                end
                LOCKED: begin
                    if (inside_btn) begin
                        state <= UNLOCK_DEBOUNCE;
                        timer <= '0;
                    end else if (code_valid) begin
                        if (code[0] == DIG_TIMEOUT) begin
                            state <= TIMEOUT_BEEP;
                        end else if (code[0] != DIG_HASH && code[0] != DIG_EMPTY &&
                                     code[MIN_DIGITS-1] != DIG_EMPTY) begin
                            state     <= CHECKING;
                            req.start <= 1'b1;
                        end
                    end
                end
                CHECKING: begin
                    if (req.done) begin
                        timer <= '0;
                        if (req.match) begin
                            state    <= AJAR;
                            attempts <= '0;
                        end else begin
                            state    <= PENALTY;
                            attempts <= attempts + 1'b1;
                        end
                    end
                end
                PENALTY: begin
                    if (timer >= block_limit) begin
                        state <= LOCKED;
                        // Count starts over after the long lockout
                        if (attempts >= attempts_t'(MAX_ATTEMPTS)) attempts <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                AJAR: begin
                    if (door_open) begin
                        state <= OPEN;
                        timer <= '0;
                    end else if (inside_btn) begin
                        state <= LOCK_DEBOUNCE;
                        timer <= '0;
                    end else if (timer >= TIMER_W'(AUTO_LOCK_CYCLES - 1)) begin
                        state <= LOCKED;  // Relock by itself
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                OPEN: begin
                    if (!door_open) begin
                        state <= AJAR;
                        timer <= '0;
                    end else if (timer >= TIMER_W'(OPEN_ALARM_CYCLES - 1)) begin
                        state <= OPEN_ALARM;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                UNLOCK_DEBOUNCE: begin
                    if (!inside_btn) begin
                        timer <= '0;
                        if (timer >= TIMER_W'(DEBOUNCE_CYCLES - 1)) begin
                            state    <= AJAR;
                            attempts <= '0;
                        end else begin
                            state <= LOCKED;  // Released too early
                        end
                    end else if (timer < TIMER_W'(DEBOUNCE_CYCLES - 1)) begin
                        timer <= timer + 1'b1;
                    end
                end
                LOCK_DEBOUNCE: begin
                    if (!inside_btn) begin
                        timer <= '0;
                        if (timer >= TIMER_W'(DEBOUNCE_CYCLES - 1)) state <= LOCKED;
                        else state <= AJAR;  // Auto-lock wait restarts
                    end else if (timer < TIMER_W'(DEBOUNCE_CYCLES - 1)) begin
                        timer <= timer + 1'b1;
                    end
                end
                TIMEOUT_BEEP: state <= LOCKED;
                OPEN_ALARM: begin
                    if (!door_open) begin
                        state <= AJAR;
                        timer <= '0;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    // Code is captured as the search starts
    always_ff @(posedge clk) begin
        if (state == LOCKED && code_valid) begin
            code_q <= code;
        end
    end

    assign lock      = state inside {LOCKED, CHECKING, PENALTY, UNLOCK_DEBOUNCE, TIMEOUT_BEEP};
    assign beep      = state inside {TIMEOUT_BEEP, OPEN_ALARM};
    assign keypad_en = state inside {LOCKED, CHECKING, TIMEOUT_BEEP};
    assign blocked   = (state == PENALTY);

endmodule

`default_nettype wire

/* door_lock_top.sv */
`timescale 1ns/100ps
`default_nettype none

module door_lock_top import lock_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  door_open,   // High while the door is physically open
    input  logic  inside_btn,
    input  code_t code,
    input  logic  code_valid,  // Single-cycle strobe from the keypad
    output logic  lock,
    output logic  beep,
    output logic  keypad_en,
    output disp_t display
);

    logic      blocked;
    attempts_t attempts;

    search_if search_bus ();
    cmp_if    cmp_bus ();

    door_fsm door_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .door_open  (door_open),
        .inside_btn (inside_btn),
        .code       (code),
        .code_valid (code_valid),
        .req        (search_bus),
        .lock       (lock),
        .beep       (beep),
        .keypad_en  (keypad_en),
        .blocked    (blocked),
        .attempts   (attempts)
    );

    code_search code_search_i (
        .clk (clk),
        .rst (rst),
        .req (search_bus),
        .chk (cmp_bus)
    );

    code_cmp code_cmp_i (
        .clk (clk),
        .rst (rst),
        .chk (cmp_bus)
    );

    lockout_display lockout_display_i (
        .blocked  (blocked),
        .attempts (attempts),
        .display  (display)
    );

endmodule

`default_nettype wire

/* list.f */
lock_types_pkg.sv
lock_cfg_pkg.sv
cmp_if.sv
search_if.sv
code_cmp.sv
code_search.sv
lockout_display.sv
door_fsm.sv
door_lock_top.sv
tb_door_lock.sv

/* lock_cfg_pkg.sv */
`default_nettype none

package lock_cfg_pkg;
    import lock_types_pkg::*;

    // Special keypad values
    localparam digit_t DIG_HASH    = 4'hB;
    localparam digit_t DIG_TIMEOUT = 4'hE;  // Keypad gave up waiting for keys
    localparam digit_t DIG_EMPTY   = 4'hF;

    // Display glyphs
    localparam digit_t DIG_MARK  = 4'hA;
    localparam digit_t DIG_BLANK = 4'hB;

    // All times in clock cycles
    localparam int DEBOUNCE_CYCLES    = 100;
    localparam int AUTO_LOCK_CYCLES   = 5000;
    localparam int OPEN_ALARM_CYCLES  = 5000;
    localparam int SHORT_BLOCK_CYCLES = 1000;
    localparam int LONG_BLOCK_CYCLES  = 30000;

    localparam int MAX_ATTEMPTS = 5;  // This wrong code starts the long lockout
    localparam int NUM_CODES    = 4;
    localparam int MIN_DIGITS   = 4;

    // Long lockout is the longest wait the shared timer has to hold
    localparam int TIMER_W    = $clog2(LONG_BLOCK_CYCLES);
    localparam int CODE_IDX_W = $clog2(NUM_CODES);

    // 1111, 2580, 0420 and 9753, typed left to right
    localparam code_t USER_CODES [NUM_CODES] = '{
        80'hFFFF_FFFF_FFFF_FFFF_1111,
        80'hFFFF_FFFF_FFFF_FFFF_2580,
        80'hFFFF_FFFF_FFFF_FFFF_0420,
        80'hFFFF_FFFF_FFFF_FFFF_9753
    };

endpackage

`default_nettype wire

/* lock_types_pkg.sv */
`default_nettype none

package lock_types_pkg;

    localparam int DIGIT_W     = 4;
    localparam int CODE_DIGITS = 20;  // Longest code the keypad can deliver
    localparam int DISP_DIGITS = 6;
    localparam int ATTEMPT_W   = 3;

    // One keypad key or one display position
    typedef logic [DIGIT_W-1:0] digit_t;

    // Digit 0 is the last key pressed, unused digits stay empty
    typedef digit_t [CODE_DIGITS-1:0] code_t;

    // Position 0 is the rightmost display digit
    typedef digit_t [DISP_DIGITS-1:0] disp_t;

    // Wrong codes since the last good code or long lockout
    typedef logic [ATTEMPT_W-1:0] attempts_t;

endpackage

`default_nettype wire

/* lockout_display.sv */
`timescale 1ns/100ps
`default_nettype none

module lockout_display import lock_types_pkg::*, lock_cfg_pkg::*; (
    input  logic      blocked,
    input  attempts_t attempts,
    output disp_t     display
);

    logic full;

    // Last allowed attempt lights every position
    assign full = (attempts >= attempts_t'(MAX_ATTEMPTS));

    // One mark per used attempt, filled from the right
    always_comb begin
        for (int i = 0; i < DISP_DIGITS; i++) begin
            if (blocked && (full || i < int'(attempts))) begin
                display[i] = DIG_MARK;
            end else begin
                display[i] = DIG_BLANK;
            end
        end
    end

endmodule

`default_nettype wire

/* search_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Search request from the door controller and its outcome
interface search_if import lock_types_pkg::*; ();

    logic  start;  // Single-cycle strobe, never repeated before done
    code_t code;
    logic  done;
    logic  match;  // Valid together with done

    modport source (
        output start, code,
        input  done, match
    );

    modport target (
        input  start, code,
        output done, match
    );

endinterface

`default_nettype wire

/* tb_door_lock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_door_lock import lock_types_pkg::*, lock_cfg_pkg::*; ();

    typedef enum {SEL_LOCK, SEL_BEEP, SEL_KEYPAD} out_sel_t;

    logic  clk;
    logic  rst;
    logic  door_open;
    logic  inside_btn;
    code_t code;
    logic  code_valid;
    logic  lock;
    logic  beep;
    logic  keypad_en;
    disp_t display;

    logic [31:0] lfsr_state;
    code_t       good_codes [4];
    logic        watch_disp;    // Display compare running
    logic        exp_blocked;
    int          exp_attempts;

    door_lock_top door_lock_top_i (
        .clk        (clk),
        .rst        (rst),
        .door_open  (door_open),
        .inside_btn (inside_btn),
        .code       (code),
        .code_valid (code_valid),
        .lock       (lock),
        .beep       (beep),
        .keypad_en  (keypad_en),
        .display    (display)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%b exp=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_disp(input string name, input disp_t got, input disp_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_min(input string name, input int got, input int lowest);
        if (got < lowest) begin
            $display("ERR %0t %s got=%0d exp>=%0d", $time, name, got, lowest);
            abort_run();
        end
    endtask

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int width);
        int val;
        val = 0;
        for (int i = 0; i < width; i++) begin
            val = (val << 1) | int'(next_rand_bit());
        end
        return val;
    endfunction

    // Keys are typed left to right so the last key ends up in digit 0
    function automatic code_t make_code(input int len, input logic [31:0] keys);
        code_t c;
        c = {CODE_DIGITS{DIG_EMPTY}};
        for (int i = 0; i < len; i++) begin
            c[i] = keys[4*i +: 4];
        end
        return c;
    endfunction

    function automatic code_t random_wrong_code();
        code_t c;
        int    len;
        logic  known;
        do begin
            len = MIN_DIGITS + rand_bits(2);
            c = {CODE_DIGITS{DIG_EMPTY}};
            for (int i = 0; i < len; i++) begin
                c[i] = digit_t'(rand_bits(4) % 10);
            end
            known = 1'b0;
            foreach (good_codes[k]) begin
                if (c == good_codes[k]) known = 1'b1;
            end
        end while (known);
        return c;
    endfunction

    // Expected display with one mark per attempt and all six on the last one
    function automatic disp_t ref_display(input logic blk, input int att);
        disp_t d;
        for (int i = 0; i < DISP_DIGITS; i++) begin
            if (blk && (att >= MAX_ATTEMPTS || i < att)) begin
                d[i] = DIG_MARK;
            end else begin
                d[i] = DIG_BLANK;
            end
        end
        return d;
    endfunction

    task automatic wait_for(input out_sel_t sel, input logic level, input int max_cycles,
                            input string what, output int cycles);
        logic now;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            case (sel)
                SEL_LOCK: now = lock;
                SEL_BEEP: now = beep;
                default:  now = keypad_en;
            endcase
        end while (now !== level && cycles < max_cycles);
        if (now !== level) begin
            $display("Timeout at %0t: %s did not go to %b within %0d cycles",
                     $time, what, level, max_cycles);
            abort_run();
        end
    endtask

    task automatic send_code(input code_t c);
        @(negedge clk);
        code       = c;
        code_valid = 1'b1;
        @(negedge clk);
        code_valid = 1'b0;
    endtask

    // Outputs must stay as in the idle locked state
    task automatic hold_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("lock", lock, 1'b1);
            check_bit("keypad_en", keypad_en, 1'b1);
            check_bit("beep", beep, 1'b0);
        end
    endtask

    task automatic unlock_with_code(input code_t c);
        int n;
        send_code(c);
        wait_for(SEL_LOCK, 1'b0, 20, "lock", n);
        exp_attempts = 0;
        check_bit("keypad_en", keypad_en, 1'b0);
        wait_for(SEL_LOCK, 1'b1, AUTO_LOCK_CYCLES + 5, "lock", n);
        check_min("auto-lock delay", n, AUTO_LOCK_CYCLES);
    endtask

    task automatic wrong_code_round();
        int n;
        int block;
        send_code(random_wrong_code());
        wait_for(SEL_KEYPAD, 1'b0, 20, "keypad_en", n);
        check_bit("lock", lock, 1'b1);
        exp_attempts++;
        exp_blocked = 1'b1;
        block = (exp_attempts >= MAX_ATTEMPTS) ? LONG_BLOCK_CYCLES : SHORT_BLOCK_CYCLES;
        wait_for(SEL_KEYPAD, 1'b1, block + 10, "keypad_en", n);
        exp_blocked = 1'b0;
        if (exp_attempts >= MAX_ATTEMPTS) exp_attempts = 0;  // Long lockout clears the count
        check_min("lockout length", n, block);
        check_bit("lock", lock, 1'b1);
    endtask

    // Display compare a little after the falling edge
    always begin
        @(negedge clk);
        #2;
        if (watch_disp) begin
            check_disp("display", display, ref_display(exp_blocked, exp_attempts));
        end
    end

    initial begin
        int n;
        rst          = 1'b1;
        door_open    = 1'b0;
        inside_btn   = 1'b0;
        code         = {CODE_DIGITS{DIG_EMPTY}};
        code_valid   = 1'b0;
        lfsr_state   = 32'h2204;
        watch_disp   = 1'b0;
        exp_blocked  = 1'b0;
        exp_attempts = 0;
        good_codes[0] = make_code(4, 32'h1111);
        good_codes[1] = make_code(4, 32'h2580);
        good_codes[2] = make_code(4, 32'h0420);
        good_codes[3] = make_code(4, 32'h9753);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_bit("lock", lock, 1'b0);
        check_bit("beep", beep, 1'b0);
        check_bit("keypad_en", keypad_en, 1'b0);
        check_disp("display", display, ref_display(1'b0, 0));
        watch_disp = 1'b1;
        wait_for(SEL_LOCK, 1'b1, 5, "lock", n);
        check_bit("keypad_en", keypad_en, 1'b1);

        // One wrong code and then codes that must be ignored
        wrong_code_round();
        send_code(make_code(3, 32'h123));
        hold_quiet(10);
        send_code(make_code(4, 32'h123B));  // Four keys ending in hash
        hold_quiet(10);
        send_code(make_code(0, 32'h0));
        hold_quiet(10);

        foreach (good_codes[k]) unlock_with_code(good_codes[k]);

        repeat (MAX_ATTEMPTS) wrong_code_round();
        wrong_code_round();  // Single mark again

        // Keypad timeout mark beeps in the cycle after the strobe
        send_code(make_code(1, 32'(DIG_TIMEOUT)));
        check_bit("beep", beep, 1'b1);
        check_bit("lock", lock, 1'b1);
        @(negedge clk);
        check_bit("beep", beep, 1'b0);
        check_bit("lock", lock, 1'b1);

        // Inside button held too short and then long enough
        inside_btn = 1'b1;
        repeat (DEBOUNCE_CYCLES / 2) begin
            @(negedge clk);
            check_bit("lock", lock, 1'b1);
        end
        inside_btn = 1'b0;
        wait_for(SEL_KEYPAD, 1'b1, 5, "keypad_en", n);
        check_bit("lock", lock, 1'b1);
        inside_btn = 1'b1;
        repeat (DEBOUNCE_CYCLES + 10) begin
            @(negedge clk);
            check_bit("lock", lock, 1'b1);
        end
        inside_btn = 1'b0;
        wait_for(SEL_LOCK, 1'b0, 5, "lock", n);
        exp_attempts = 0;

        // Door left open too long
        door_open = 1'b1;
        wait_for(SEL_BEEP, 1'b1, OPEN_ALARM_CYCLES + 10, "beep", n);
        check_min("open alarm delay", n, OPEN_ALARM_CYCLES);
        door_open = 1'b0;
        wait_for(SEL_BEEP, 1'b0, 3, "beep", n);
        wait_for(SEL_LOCK, 1'b1, AUTO_LOCK_CYCLES + 10, "lock", n);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
